//--- compile.f
+incdir+hw
hw/sq_pkg.sv
hw/sq_alloc.sv
hw/sq_entry_array.sv
hw/sq_drain.sv
hw/store_queue.sv
tb/store_queue_tb.sv

//--- hw/sq_alloc.sv
`timescale 1ns/1ns
`default_nettype none

module sq_alloc (
  input  logic            clock,
  input  logic            reset,
  input  logic            alloc_req,
  input  sq_pkg::sq_idx_t head,
  output logic            alloc_ready,
  output sq_pkg::sq_idx_t alloc_idx,
  output logic            alloc_fire
);

  sq_pkg::sq_idx_t tail;
  sq_pkg::sq_idx_t tail_plus_one;

  assign tail_plus_one = tail + 1'b1;

  // Full when the next tail would land on the head
  assign alloc_ready = tail_plus_one != head;

  // New store takes the current tail slot
  assign alloc_idx = tail;

  // Requests while full are simply dropped
  assign alloc_fire = alloc_req && alloc_ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      tail <= '0;
    end else if (alloc_fire) begin
      tail <= tail_plus_one;
    end
  end

endmodule

`default_nettype wire

//--- hw/sq_drain.sv
`timescale 1ns/1ns
`default_nettype none

module sq_drain (
  input  logic                clock,
  input  logic                reset,
  input  logic                commit,
  input  sq_pkg::word_addr_t  head_addr,
  input  sq_pkg::store_data_t head_data,
  output sq_pkg::sq_idx_t     head,
  output logic                mem_req,
  output sq_pkg::word_addr_t  mem_addr,
  output sq_pkg::store_data_t mem_data,
  input  logic                mem_ack
);

  sq_pkg::drain_state_t state;
  sq_pkg::drain_state_t state_next;
  sq_pkg::sq_idx_t      commit_ptr;
  logic                 pending;
  logic                 launch;
  logic                 retire;

  // Committed stores not yet written out
  assign pending = head != commit_ptr;

  always_comb begin
    state_next = state;
    launch     = 1'b0;
    retire     = 1'b0;
    case (state)
      sq_pkg::DRAIN_IDLE: begin
        if (pending) begin
          launch     = 1'b1;
          state_next = sq_pkg::DRAIN_REQ;
        end
      end
      sq_pkg::DRAIN_REQ: begin
        if (mem_ack) begin
          retire     = 1'b1;
          state_next = sq_pkg::DRAIN_WAIT_LOW;
        end
      end
      sq_pkg::DRAIN_WAIT_LOW: begin
        // Back-to-back write once the ack has gone low
        if (!mem_ack) begin
          launch     = pending;
          state_next = pending ? sq_pkg::DRAIN_REQ : sq_pkg::DRAIN_IDLE;
        end
      end
      default: begin
        state_next = sq_pkg::DRAIN_IDLE;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= sq_pkg::DRAIN_IDLE;
      head       <= '0;
      commit_ptr <= '0;
    end else begin
      state <= state_next;
      if (retire) begin
        head <= head + 1'b1;
      end
      if (commit) begin
        commit_ptr <= commit_ptr + 1'b1;
      end
    end
  end

  // Held stable for the whole request phase
  always_ff @(posedge clock) begin
    if (launch) begin
      mem_addr <= head_addr;
      mem_data <= head_data;
    end
  end

  assign mem_req = state == sq_pkg::DRAIN_REQ;

endmodule

`default_nettype wire

//--- hw/sq_entry_array.sv
`timescale 1ns/1ns
`default_nettype none

`include "sq_settings.svh"

module sq_entry_array (
  input  logic                clock,
  input  logic                reset,
  input  logic                alloc_fire,
  input  sq_pkg::sq_idx_t     alloc_idx,
  input  logic                exec_valid,
  input  sq_pkg::sq_idx_t     exec_idx,
  input  sq_pkg::word_addr_t  exec_addr,
  input  sq_pkg::store_data_t exec_data,
  input  logic                ld_req,
  input  sq_pkg::word_addr_t  ld_addr,
  input  sq_pkg::sq_idx_t     ld_tail,
  input  sq_pkg::sq_idx_t     head,
  output logic                fwd_valid,
  output logic                fwd_hit,
  output sq_pkg::store_data_t fwd_data,
  output sq_pkg::word_addr_t  head_addr,
  output sq_pkg::store_data_t head_data
);

  logic [`SQ_DEPTH-1:0] entry_valid;
  sq_pkg::word_addr_t   entry_addr [`SQ_DEPTH];
  sq_pkg::store_data_t  entry_data [`SQ_DEPTH];

  // Lookup datapath
  sq_pkg::sq_idx_t      older_count;
  sq_pkg::sq_idx_t      age_slot [`SQ_DEPTH];
  logic                 match_hit;
  sq_pkg::store_data_t  match_data;

  // Valid bit: cleared at allocation, set once the store has executed
  always_ff @(posedge clock) begin
    if (reset) begin
      entry_valid <= '0;
    end else begin
      if (alloc_fire) begin
        entry_valid[alloc_idx] <= 1'b0;
      end
      if (exec_valid) begin
        entry_valid[exec_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (exec_valid) begin
      entry_addr[exec_idx] <= exec_addr;
      entry_data[exec_idx] <= exec_data;
    end
  end

  // Oldest entry goes straight to the drain
  assign head_addr = entry_addr[head];
  assign head_data = entry_data[head];

  // Stores older than the load sit in head .. ld_tail-1
  assign older_count = ld_tail - head;

  // Age 0 is the head, larger ages are younger stores
  always_comb begin
    for (int j = 0; j < `SQ_DEPTH; j++) begin
      age_slot[j] = head + sq_pkg::sq_idx_t'(j);
    end
  end

  // Walk from the youngest older store toward the head, first match wins
  always_comb begin
    match_hit  = 1'b0;
    match_data = '0;
    for (int j = `SQ_DEPTH - 1; j >= 0; j--) begin
      if (!match_hit && sq_pkg::sq_idx_t'(j) < older_count &&
          entry_valid[age_slot[j]] && entry_addr[age_slot[j]] == ld_addr) begin
        match_hit  = 1'b1;
        match_data = entry_data[age_slot[j]];
      end
    end
  end

  // One cycle of lookup latency, a new load may enter every cycle
  always_ff @(posedge clock) begin
    if (reset) begin
      fwd_valid <= 1'b0;
      fwd_hit   <= 1'b0;
    end else begin
      fwd_valid <= ld_req;
      fwd_hit   <= ld_req && match_hit;
    end
  end

  // Zero on a miss
  always_ff @(posedge clock) begin
    fwd_data <= ld_req ? match_data : '0;
  end

endmodule

`default_nettype wire

//--- hw/sq_pkg.sv
`default_nettype none

`include "sq_settings.svh"

package sq_pkg;

  // Slot index and queue pointer, wraps at SQ_DEPTH
  typedef logic [`SQ_IDX_W-1:0] sq_idx_t;

  typedef logic [`WORD_ADDR_W-1:0] word_addr_t;

  typedef logic [`STORE_DATA_W-1:0] store_data_t;

  // Four-phase write toward memory
  typedef enum logic [1:0] {
    DRAIN_IDLE,
    DRAIN_REQ,
    DRAIN_WAIT_LOW
  } drain_state_t;

endpackage

`default_nettype wire

//--- hw/sq_settings.svh
`ifndef SQ_SETTINGS_SVH
`define SQ_SETTINGS_SVH

// Queue geometry, one slot always stays empty
`define SQ_DEPTH 8
`define SQ_IDX_W 3

// Word address drops the low three byte bits
`define WORD_ADDR_W 29

`define STORE_DATA_W 64

`endif

//--- hw/store_queue.sv
`timescale 1ns/1ns
`default_nettype none

module store_queue (
  input  logic                clock,
  input  logic                reset,
  input  logic                alloc_req,
  output logic                alloc_ready,
  output sq_pkg::sq_idx_t     alloc_idx,
  input  logic                exec_valid,
  input  sq_pkg::sq_idx_t     exec_idx,
  input  sq_pkg::word_addr_t  exec_addr,
  input  sq_pkg::store_data_t exec_data,
  input  logic                ld_req,
  input  sq_pkg::word_addr_t  ld_addr,
  input  sq_pkg::sq_idx_t     ld_tail,
  output logic                fwd_valid,
  output logic                fwd_hit,
  output sq_pkg::store_data_t fwd_data,
  input  logic                commit,
  output logic                mem_req,
  output sq_pkg::word_addr_t  mem_addr,
  output sq_pkg::store_data_t mem_data,
  input  logic                mem_ack
);

  logic                alloc_fire;
  sq_pkg::sq_idx_t     head;
  sq_pkg::word_addr_t  head_addr;
  sq_pkg::store_data_t head_data;

  sq_alloc u_alloc (
    .clock       (clock),
    .reset       (reset),
    .alloc_req   (alloc_req),
    .head        (head),
    .alloc_ready (alloc_ready),
    .alloc_idx   (alloc_idx),
    .alloc_fire  (alloc_fire)
  );

  sq_entry_array u_entries (
    .clock      (clock),
    .reset      (reset),
    .alloc_fire (alloc_fire),
    .alloc_idx  (alloc_idx),
    .exec_valid (exec_valid),
    .exec_idx   (exec_idx),
    .exec_addr  (exec_addr),
    .exec_data  (exec_data),
    .ld_req     (ld_req),
    .ld_addr    (ld_addr),
    .ld_tail    (ld_tail),
    .head       (head),
    .fwd_valid  (fwd_valid),
    .fwd_hit    (fwd_hit),
    .fwd_data   (fwd_data),
    .head_addr  (head_addr),
    .head_data  (head_data)
  );

  // Head pointer lives with the drain, freeing slots as writes complete
  sq_drain u_drain (
    .clock     (clock),
    .reset     (reset),
    .commit    (commit),
    .head_addr (head_addr),
    .head_data (head_data),
    .head      (head),
    .mem_req   (mem_req),
    .mem_addr  (mem_addr),
    .mem_data  (mem_data),
    .mem_ack   (mem_ack)
  );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f compile.f --top-module store_queue_tb -o store_queue_sim

./obj_dir/store_queue_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Simulation PASSED" sim.log; then
  echo "run_sim: test passed"
  exit 0
else
  echo "run_sim: test failed"
  exit 1
fi

//--- tb/store_queue_tb.sv
`timescale 1ns/1ns
`default_nettype none

module store_queue_tb;

  typedef enum logic [2:0] {
    OP_IDLE,
    OP_ALLOC,
    OP_EXEC,
    OP_LOAD,
    OP_COMMIT,
    OP_DRAIN
  } op_t;

  // idx is the expected alloc_idx, the exec slot or the load's ld_tail
  // data is exec data, expected forward data or expected memory data
  typedef struct {
    op_t                 op;
    sq_pkg::sq_idx_t     idx;
    sq_pkg::word_addr_t  addr;
    sq_pkg::store_data_t data;
    logic                exp_ready;
    logic                exp_hit;
  } row_t;

  logic                clock;
  logic                reset;
  logic                alloc_req;
  logic                alloc_ready;
  sq_pkg::sq_idx_t     alloc_idx;
  logic                exec_valid;
  sq_pkg::sq_idx_t     exec_idx;
  sq_pkg::word_addr_t  exec_addr;
  sq_pkg::store_data_t exec_data;
  logic                ld_req;
  sq_pkg::word_addr_t  ld_addr;
  sq_pkg::sq_idx_t     ld_tail;
  logic                fwd_valid;
  logic                fwd_hit;
  sq_pkg::store_data_t fwd_data;
  logic                commit;
  logic                mem_req;
  sq_pkg::word_addr_t  mem_addr;
  sq_pkg::store_data_t mem_data;
  logic                mem_ack;

  row_t                rows [$];
  sq_pkg::word_addr_t  exp_wr_addr [$];
  sq_pkg::store_data_t exp_wr_data [$];
  int                  errors = 0;
  int                  checks = 0;
  int                  cycle_count = 0;
  int                  cycle_limit = 0;
  logic [31:0]         lfsr_state = 32'd93452;

  store_queue u_dut (
    .clock       (clock),
    .reset       (reset),
    .alloc_req   (alloc_req),
    .alloc_ready (alloc_ready),
    .alloc_idx   (alloc_idx),
    .exec_valid  (exec_valid),
    .exec_idx    (exec_idx),
    .exec_addr   (exec_addr),
    .exec_data   (exec_data),
    .ld_req      (ld_req),
    .ld_addr     (ld_addr),
    .ld_tail     (ld_tail),
    .fwd_valid   (fwd_valid),
    .fwd_hit     (fwd_hit),
    .fwd_data    (fwd_data),
    .commit      (commit),
    .mem_req     (mem_req),
    .mem_addr    (mem_addr),
    .mem_data    (mem_data),
    .mem_ack     (mem_ack)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic [31:0] shifted;
    shifted = state >> 1;
    if (state[0]) begin
      shifted = shifted ^ 32'h8020_0003;
    end
    return shifted;
  endfunction

  task automatic check_idx(input string name, input sq_pkg::sq_idx_t got,
                           input sq_pkg::sq_idx_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input sq_pkg::word_addr_t got,
                            input sq_pkg::word_addr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_data(input string name, input sq_pkg::store_data_t got,
                            input sq_pkg::store_data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic add_row(input op_t op, input sq_pkg::sq_idx_t idx,
                         input sq_pkg::word_addr_t addr, input sq_pkg::store_data_t data,
                         input logic exp_ready, input logic exp_hit);
    row_t row;
    row.op        = op;
    row.idx       = idx;
    row.addr      = addr;
    row.data      = data;
    row.exp_ready = exp_ready;
    row.exp_hit   = exp_hit;
    rows.push_back(row);
  endtask

  task automatic build_rows();
    // Fill up to capacity and then request twice while full
    for (int i = 0; i < 7; i++) begin
      add_row(OP_ALLOC, sq_pkg::sq_idx_t'(i), '0, '0, 1'b1, 1'b0);
    end
    add_row(OP_ALLOC, 3'd7, '0, '0, 1'b0, 1'b0);
    add_row(OP_ALLOC, 3'd7, '0, '0, 1'b0, 1'b0);
    // Youngest older store to the same address forwards
    add_row(OP_EXEC, 3'd0, 29'h0000_1000, 64'h1111_0000_0000_00a0, 1'b0, 1'b0);
    add_row(OP_EXEC, 3'd1, 29'h0000_1000, 64'h2222_0000_0000_00a1, 1'b0, 1'b0);
    add_row(OP_LOAD, 3'd2, 29'h0000_1000, 64'h2222_0000_0000_00a1, 1'b0, 1'b1);
    add_row(OP_LOAD, 3'd1, 29'h0000_1000, 64'h1111_0000_0000_00a0, 1'b0, 1'b1);
    add_row(OP_LOAD, 3'd0, 29'h0000_1000, 64'h0, 1'b0, 1'b0);
    add_row(OP_EXEC, 3'd2, 29'h0000_1bb0, 64'h3333_0000_0000_00b2, 1'b0, 1'b0);
    add_row(OP_LOAD, 3'd2, 29'h0000_1bb0, 64'h0, 1'b0, 1'b0);
    add_row(OP_LOAD, 3'd3, 29'h0000_1bb0, 64'h3333_0000_0000_00b2, 1'b0, 1'b1);
    add_row(OP_LOAD, 3'd7, 29'h0ccc_0000, 64'h0, 1'b0, 1'b0);
    add_row(OP_EXEC, 3'd3, 29'h0000_2003, 64'h4444_0000_0000_0003, 1'b0, 1'b0);
    add_row(OP_EXEC, 3'd4, 29'h0000_2004, 64'h5555_0000_0000_0004, 1'b0, 1'b0);
    add_row(OP_EXEC, 3'd5, 29'h1fff_fff5, 64'hffff_ffff_ffff_0005, 1'b0, 1'b0);
    add_row(OP_EXEC, 3'd6, 29'h0000_2006, 64'h7777_0000_0000_0006, 1'b0, 1'b0);
    // Retire all seven in program order
    add_row(OP_COMMIT, 3'd0, 29'h0000_1000, 64'h1111_0000_0000_00a0, 1'b0, 1'b0);
    add_row(OP_COMMIT, 3'd1, 29'h0000_1000, 64'h2222_0000_0000_00a1, 1'b0, 1'b0);
    add_row(OP_COMMIT, 3'd2, 29'h0000_1bb0, 64'h3333_0000_0000_00b2, 1'b0, 1'b0);
    add_row(OP_COMMIT, 3'd3, 29'h0000_2003, 64'h4444_0000_0000_0003, 1'b0, 1'b0);
    add_row(OP_COMMIT, 3'd4, 29'h0000_2004, 64'h5555_0000_0000_0004, 1'b0, 1'b0);
    add_row(OP_COMMIT, 3'd5, 29'h1fff_fff5, 64'hffff_ffff_ffff_0005, 1'b0, 1'b0);
    add_row(OP_COMMIT, 3'd6, 29'h0000_2006, 64'h7777_0000_0000_0006, 1'b0, 1'b0);
    add_row(OP_DRAIN, 3'd0, '0, '0, 1'b0, 1'b0);
    // Head now at 7 so allocation wraps to slot 0
    add_row(OP_ALLOC, 3'd7, '0, '0, 1'b1, 1'b0);
    add_row(OP_ALLOC, 3'd0, '0, '0, 1'b1, 1'b0);
    add_row(OP_ALLOC, 3'd1, '0, '0, 1'b1, 1'b0);
    add_row(OP_EXEC, 3'd7, 29'h0000_3e00, 64'h8888_0000_0000_00e7, 1'b0, 1'b0);
    add_row(OP_EXEC, 3'd0, 29'h0000_3f00, 64'h9999_0000_0000_00f0, 1'b0, 1'b0);
    add_row(OP_LOAD, 3'd1, 29'h0000_3f00, 64'h9999_0000_0000_00f0, 1'b0, 1'b1);
    add_row(OP_LOAD, 3'd0, 29'h0000_3e00, 64'h8888_0000_0000_00e7, 1'b0, 1'b1);
    add_row(OP_COMMIT, 3'd7, 29'h0000_3e00, 64'h8888_0000_0000_00e7, 1'b0, 1'b0);
    add_row(OP_COMMIT, 3'd0, 29'h0000_3f00, 64'h9999_0000_0000_00f0, 1'b0, 1'b0);
    add_row(OP_DRAIN, 3'd0, '0, '0, 1'b0, 1'b0);
    add_row(OP_ALLOC, 3'd2, '0, '0, 1'b1, 1'b0);
  endtask

  task automatic drive_row(input row_t row);
    alloc_req  <= row.op == OP_ALLOC;
    exec_valid <= row.op == OP_EXEC;
    exec_idx   <= row.idx;
    exec_addr  <= row.addr;
    exec_data  <= row.data;
    ld_req     <= row.op == OP_LOAD;
    ld_addr    <= row.addr;
    ld_tail    <= row.idx;
    commit     <= row.op == OP_COMMIT;
  endtask

  task automatic clear_inputs();
    alloc_req  <= 1'b0;
    exec_valid <= 1'b0;
    exec_idx   <= '0;
    exec_addr  <= '0;
    exec_data  <= '0;
    ld_req     <= 1'b0;
    ld_addr    <= '0;
    ld_tail    <= '0;
    commit     <= 1'b0;
  endtask

  task automatic print_counts();
    $display("Checks: %0d, errors: %0d", checks, errors);
  endtask

  // Memory side of the four-phase write with random ack latency
  initial begin : mem_responder
    logic [2:0] delay;
    mem_ack <= 1'b0;
    forever begin
      @(negedge clock);
      if (mem_req && !mem_ack) begin
        delay = 3'd0;
        for (int b = 0; b < 3; b++) begin
          delay = {delay[1:0], lfsr_state[0]};
          lfsr_state = lfsr_next(lfsr_state);
        end
        repeat (delay) @(posedge clock);
        @(negedge clock);
        $display("Memory write addr 0x%h data 0x%h", mem_addr, mem_data);
        if (exp_wr_addr.size() == 0) begin
          errors++;
          $display("Memory write arrived with no committed store waiting");
        end else begin
          check_addr("mem_addr", mem_addr, exp_wr_addr.pop_front());
          check_data("mem_data", mem_data, exp_wr_data.pop_front());
        end
        @(posedge clock);
        mem_ack <= 1'b1;
        @(negedge clock);
        while (mem_req) @(negedge clock);
        @(posedge clock);
        mem_ack <= 1'b0;
      end
    end
  end

  initial begin : handshake_monitor
    logic req_prev;
    logic ack_prev;
    req_prev = 1'b0;
    ack_prev = 1'b0;
    forever begin
      @(negedge clock);
      // Ack level as seen by the edge that raised the request
      if (mem_req && !req_prev && ack_prev) begin
        errors++;
        $display("mem_req rose while mem_ack was still high");
      end
      req_prev = mem_req;
      ack_prev = mem_ack;
    end
  end

  initial begin : watchdog
    @(posedge clock);
    while (cycle_count < cycle_limit) begin
      @(posedge clock);
      cycle_count++;
    end
    $display("Run stopped at the cycle limit of %0d cycles", cycle_limit);
    print_counts();
    $display("Simulation FAILED");
    $finish;
  end

  initial begin : stimulus
    row_t row;
    reset <= 1'b1;
    clear_inputs();
    build_rows();
    cycle_limit = 40 * rows.size();
    repeat (8) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
    check_bit("alloc_ready", alloc_ready, 1'b1);
    check_bit("fwd_valid", fwd_valid, 1'b0);
    check_bit("mem_req", mem_req, 1'b0);
    for (int r = 0; r < rows.size(); r++) begin
      row = rows[r];
      @(posedge clock);
      drive_row(row);
      @(negedge clock);
      // No lookup was sampled on the previous edge
      check_bit("fwd_valid", fwd_valid, 1'b0);
      case (row.op)
        OP_ALLOC: begin
          check_bit("alloc_ready", alloc_ready, row.exp_ready);
          check_idx("alloc_idx", alloc_idx, row.idx);
        end
        OP_LOAD: begin
          // Result shows up exactly one cycle after the request
          @(posedge clock);
          clear_inputs();
          @(negedge clock);
          check_bit("fwd_valid", fwd_valid, 1'b1);
          check_bit("fwd_hit", fwd_hit, row.exp_hit);
          check_data("fwd_data", fwd_data, row.data);
        end
        OP_COMMIT: begin
          exp_wr_addr.push_back(row.addr);
          exp_wr_data.push_back(row.data);
        end
        OP_DRAIN: begin
          while (exp_wr_addr.size() != 0 || mem_req || mem_ack) @(negedge clock);
        end
        default: begin
        end
      endcase
    end
    @(posedge clock);
    clear_inputs();
    @(negedge clock);
    print_counts();
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
